//--- jt900h.f
+incdir+include
hw/jt900h_pkg.sv
hw/jt900h_if.sv
hw/jt900h_regs.sv
hw/jt900h_alu.sv
hw/jt900h_ramctl.sv
hw/jt900h_pc.sv
hw/jt900h_ctrl.sv
hw/jt900h.sv
bench/jt900h_checker.sv
bench/jt900h_tb.sv

//--- bench/jt900h_cases.txt
# case <name> <word count> <program words, hex>
# regs <r0 .. r7, hex> stores <count> <address data, hex> ...
# load immediate into every register
case ldi_all 17
0000 1201 0200 3403 0400 5605 0600 7807 0800 9a09 0a00 bc0b 0c00 de0d 0e00 f00f 7000
regs 1201 3403 5605 7807 9a09 bc0b de0d f00f
stores 0
# add sub and or xor against r7, cp then jrz and jrnz over loads of r0
case alu_ops 28
0e00 0f0f 0200 f234 13c0 0400 1234 15c8 0600 1234 17d0 0800 1234 19d8
0a00 1234 1be0 0c00 0f0f 1de8 4002 0000 dead 13e8 5002 0000 beef 7000
regs 0000 0143 0325 0204 1f3f 1d3b 0f0f 0f0f
stores 0
# store through r1 and r4, load back into r3
case load_store 10
0200 0040 0400 a55a 3440 2640 0800 0041 3700 7000
regs 0000 0040 a55a a55a 0041 0000 0000 0000
stores 2 0040 a55a 0041 a55a
# r2 += r1 five times under djnz r3, accumulator stored at 0080
case djnz_loop 10
0200 0123 0600 0005 1440 66fe 0800 0080 3500 7000
regs 0000 0123 05af 0000 0080 0000 0000 0000
stores 1 0080 05af
# jrz forward over the load of r3, then jrz back to the load of r5
case branches 14
0200 0001 0400 0001 12a8 4005 0600 bad0 0a00 0055 7000 0c00 0066 40fa
regs 0000 0001 0001 0000 0000 0055 0066 0000
stores 0

//--- bench/jt900h_tb.sv
// ==========================================================
// jt900h_tb: clock, reset, case loader, memory model
// and timeout; runs every case without and with ack delay
// ==========================================================
`timescale 1ns/1ps
`include "jt900h_macros.svh"

module jt900h_tb;

logic                    clk, rst_n, cen;
logic [`JT900H_AW-1:0]   ram_addr;
logic [`JT900H_DW-1:0]   ram_wdata, ram_rdata;
logic                    ram_we, ram_req, ram_ack;
logic [7:0]              dmp_addr, dmp_din;
logic                    halted;

logic [8*16-1:0]         case_name;
logic [8*`JT900H_DW-1:0] exp_regs;
logic [8*32-1:0]         exp_st;
logic [3:0]              exp_nst;
logic                    dmp_on, case_end, delay_on;
logic [`JT900H_DW-1:0]   mem  [256];
logic [`JT900H_DW-1:0]   prog [256];
int                      prog_len, limit, bench_errs;
int                      cycles = 0;
int                      delays [1024];
int                      val_errs, other_errs;

jt900h u_dut(
    .clk(clk), .rst_n(rst_n), .cen(cen),
    .ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_we(ram_we), .ram_req(ram_req),
    .ram_ack(ram_ack), .ram_rdata(ram_rdata),
    .dmp_addr(dmp_addr), .dmp_din(dmp_din), .halted(halted)
);

jt900h_checker u_chk(
    .clk(clk), .rst_n(rst_n), .case_name(case_name), .exp_regs(exp_regs),
    .exp_st(exp_st), .exp_nst(exp_nst), .case_end(case_end),
    .ram_req(ram_req), .ram_ack(ram_ack), .ram_we(ram_we), .ram_addr(ram_addr),
    .ram_wdata(ram_wdata), .dmp_on(dmp_on), .dmp_addr(dmp_addr), .dmp_din(dmp_din),
    .val_errs(val_errs), .other_errs(other_errs)
);

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
end

// four-phase memory, reloads the program while reset is low
initial begin
    int a;
    int ack_wait;
    int acc_idx;
    logic in_access;
    ram_ack   = 1'b0;
    ram_rdata = '0;
    in_access = 1'b0;
    ack_wait  = 0;
    acc_idx   = 0;
    forever begin
        @(negedge clk);
        if (!rst_n) begin
            ram_ack   = 1'b0;
            in_access = 1'b0;
            for (a = 0; a < 256; a++)
                mem[a] = a < prog_len ? prog[a] : 16'hc000 | a[7:0];  // fill decodes as nop
        end else if (ram_ack) begin
            if (!ram_req) ram_ack = 1'b0;
        end else if (ram_req && !in_access) begin
            in_access = 1'b1;
            ack_wait  = delay_on ? delays[acc_idx % 1024] : 0;
            acc_idx++;
        end else if (in_access && ack_wait > 0) begin
            ack_wait--;
        end else if (in_access) begin
            in_access = 1'b0;
            ram_ack   = 1'b1;
            if (ram_we) mem[ram_addr[7:0]] = ram_wdata;
            else ram_rdata = mem[ram_addr[7:0]];
        end
    end
end

always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
        $display("timeout in case %0s: no halt within %0d cycles", case_name, limit);
        $display("errors: %0d wrong values, %0d other failures", val_errs, other_errs + 1);
        $display("Done: errors found");
        $finish;
    end
end

task automatic run_case;
    int i;
    @(negedge clk);
    rst_n = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    while (!halted) @(negedge clk);
    for (i = 0; i < 16; i++) begin      // reg i/2, low byte first
        dmp_on   = 1'b1;
        dmp_addr = i[7:0];
        @(negedge clk);
    end
    dmp_on = 1'b0;
    @(negedge clk);
    case_end = 1'b1;
    @(negedge clk);
    case_end = 1'b0;
endtask

initial begin
    int fd, n, i, nw, nst, pass, seed_val;
    logic [8*16-1:0]  tok;
    logic [8*128-1:0] line;
    logic [15:0]      w, a, d;
    rst_n      = 1'b0;
    cen        = 1'b1;
    dmp_addr   = '0;
    dmp_on     = 1'b0;
    case_end   = 1'b0;
    delay_on   = 1'b0;
    prog_len   = 0;
    limit      = 0;
    bench_errs = 0;
    case_name  = "none";
    exp_regs   = '0;
    exp_st     = '0;
    exp_nst    = '0;
    seed_val   = $urandom(32'hf451_d6bc);
    for (i = 0; i < 1024; i++) delays[i] = $urandom % 4;   // 0 to 3 extra cycles
    for (pass = 0; pass < 2; pass++) begin
        fd = $fopen("bench/jt900h_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/jt900h_cases.txt");
            bench_errs++;
        end else begin
            delay_on = pass == 1;
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok == "#") begin
                    n = $fgets(line, fd);
                end else if (tok == "case") begin
                    n = $fscanf(fd, "%s %d", case_name, nw);
                    for (i = 0; i < nw; i++) begin
                        n = $fscanf(fd, "%h", w);
                        prog[i] = w;
                    end
                    n = $fscanf(fd, "%s", tok);
                    for (i = 0; i < 8; i++) begin
                        n = $fscanf(fd, "%h", w);
                        exp_regs[i*16 +: 16] = w;
                    end
                    n = $fscanf(fd, "%s %d", tok, nst);
                    for (i = 0; i < nst; i++) begin
                        n = $fscanf(fd, "%h %h", a, d);
                        exp_st[i*32 +: 32] = {a, d};
                    end
                    exp_nst  = nst[3:0];
                    prog_len = nw;
                    limit    = limit + nw * 4 * 8 + 100;
                    run_case();
                end
            end
            $fclose(fd);
        end
    end
    $display("errors: %0d wrong values, %0d other failures",
             val_errs, other_errs + bench_errs);
    if (val_errs + other_errs + bench_errs == 0)
        $display("Done: no errors");
    else
        $display("Done: errors found");
    $finish;
end

endmodule

//--- bench/jt900h_checker.sv
// ==========================================================
// jt900h_checker: store and register dump checker
// logs write handshakes in order, compares dump bytes,
// keeps the error counts
// ==========================================================
`timescale 1ns/1ps
`include "jt900h_macros.svh"

module jt900h_checker(
    input                          clk,
    input                          rst_n,
    input      [8*16-1:0]          case_name,
    input      [8*`JT900H_DW-1:0]  exp_regs,    // r0 in the low word
    input      [8*32-1:0]          exp_st,      // {addr, data} pairs, first one lowest
    input      [3:0]               exp_nst,
    input                          case_end,
    // bus and dump port of the DUT
    input                          ram_req,
    input                          ram_ack,
    input                          ram_we,
    input      [`JT900H_AW-1:0]    ram_addr,
    input      [`JT900H_DW-1:0]    ram_wdata,
    input                          dmp_on,
    input      [7:0]               dmp_addr,
    input      [7:0]               dmp_din,
    output int                     val_errs,
    output int                     other_errs
);

int          val_cnt = 0;
int          other_cnt = 0;
int          st_idx;
logic        dmp_pend;
logic [3:0]  pend_addr;
logic [7:0]  exp_byte;
logic [31:0] exp_pair;

assign val_errs   = val_cnt;
assign other_errs = other_cnt;

always @(posedge clk) begin
    if (!rst_n) begin
        st_idx   = 0;
        dmp_pend = 1'b0;
    end else begin
        // req and ack are both high on exactly one edge per access
        if (ram_req && ram_ack && ram_we) begin
            if (st_idx >= exp_nst) begin
                $display("%0s: unexpected store of %h to address %h",
                         case_name, ram_wdata, ram_addr);
                other_cnt++;
            end else begin
                exp_pair = exp_st[st_idx*32 +: 32];
                if ({ram_addr, ram_wdata} !== exp_pair) begin
                    $display("FAIL %0s store %0d: expected %h at %h, actual %h at %h",
                             case_name, st_idx, exp_pair[15:0], exp_pair[31:16],
                             ram_wdata, ram_addr);
                    val_cnt++;
                end
            end
            st_idx++;
        end
        if (dmp_pend) begin     // byte registered on the previous edge
            exp_byte = exp_regs[pend_addr*8 +: 8];
            if (dmp_din !== exp_byte) begin
                $display("FAIL %0s dump byte %0d: expected %h, actual %h",
                         case_name, pend_addr, exp_byte, dmp_din);
                val_cnt++;
            end
        end
        dmp_pend  = dmp_on;
        pend_addr = dmp_addr[3:0];
        if (case_end && st_idx < exp_nst) begin
            $display("%0s: only %0d of %0d expected stores happened",
                     case_name, st_idx, exp_nst);
            other_cnt++;
        end
    end
end

endmodule

//--- hw/jt900h.sv
// ==========================================================
// jt900h: top level of the cut-down 900H core
// controller, register bank, ALU, RAM controller and PC
// ==========================================================
`timescale 1ns/1ps
`include "jt900h_macros.svh"

module jt900h(
    input                         clk,
    input                         rst_n,
    input                         cen,
    // external memory bus
    output    [`JT900H_AW-1:0]    ram_addr,
    output    [`JT900H_DW-1:0]    ram_wdata,
    output                        ram_we,
    output                        ram_req,
    input                         ram_ack,
    input     [`JT900H_DW-1:0]    ram_rdata,
    // register dump
    input     [7:0]               dmp_addr,
    output    [7:0]               dmp_din,
    output                        halted
);

logic                  mem_rd, mem_wr, mem_sel, mem_rdy;
logic [`JT900H_DW-1:0] mem_dout;
logic                  pc_inc, pc_rel;
logic [7:0]            rel_off;
logic [`JT900H_AW-1:0] pc;

regs_if rg();
alu_if  al();

jt900h_ctrl u_ctrl(
    .clk        ( clk       ),
    .rst_n      ( rst_n     ),
    .cen        ( cen       ),
    .rg         ( rg.ctrl   ),
    .al         ( al.ctrl   ),
    .mem_rd     ( mem_rd    ),
    .mem_wr     ( mem_wr    ),
    .mem_sel    ( mem_sel   ),
    .mem_rdy    ( mem_rdy   ),
    .mem_dout   ( mem_dout  ),
    .pc_inc     ( pc_inc    ),
    .pc_rel     ( pc_rel    ),
    .rel_off    ( rel_off   ),
    .halted     ( halted    )
);

jt900h_regs u_regs(
    .clk        ( clk       ),
    .rst_n      ( rst_n     ),
    .cen        ( cen       ),
    .rg         ( rg.regs   ),
    .alu_dout   ( al.dout   ),
    .mem_dout   ( mem_dout  ),
    .dmp_addr   ( dmp_addr  ),
    .dmp_din    ( dmp_din   )
);

jt900h_alu u_alu(
    .clk        ( clk       ),
    .rst_n      ( rst_n     ),
    .cen        ( cen       ),
    .al         ( al.alu    ),
    .rg         ( rg.alu    )
);

jt900h_ramctl u_ramctl(
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .cen        ( cen        ),
    .mem_rd     ( mem_rd     ),
    .mem_wr     ( mem_wr     ),
    .mem_sel    ( mem_sel    ),
    .pc         ( pc         ),
    .daddr      ( rg.src_out ),   // register-indirect only
    .wdata      ( rg.dst_out ),
    .mem_rdy    ( mem_rdy    ),
    .mem_dout   ( mem_dout   ),
    .ram_addr   ( ram_addr   ),
    .ram_wdata  ( ram_wdata  ),
    .ram_we     ( ram_we     ),
    .ram_req    ( ram_req    ),
    .ram_ack    ( ram_ack    ),
    .ram_rdata  ( ram_rdata  )
);

jt900h_pc u_pc(
    .clk        ( clk       ),
    .rst_n      ( rst_n     ),
    .cen        ( cen       ),
    .inc        ( pc_inc    ),
    .rel        ( pc_rel    ),
    .off        ( rel_off   ),
    .pc         ( pc        )
);

endmodule

//--- hw/jt900h_ctrl.sv
// ==========================================================
// jt900h_ctrl: instruction register and sequencing FSM
// fetch, decode, ALU issue, memory access, branch decision
// ==========================================================
`timescale 1ns/1ps
`include "jt900h_macros.svh"

module jt900h_ctrl(
    input                         clk,
    input                         rst_n,
    input                         cen,
    regs_if.ctrl                  rg,
    alu_if.ctrl                   al,
    // RAM controller
    output logic                  mem_rd,
    output logic                  mem_wr,
    output logic                  mem_sel,   // 0 = pc, 1 = src register
    input                         mem_rdy,
    input      [`JT900H_DW-1:0]   mem_dout,
    // program counter
    output logic                  pc_inc,
    output logic                  pc_rel,
    output logic [7:0]            rel_off,
    output logic                  halted
);

jt900h_pkg::cpu_state_t state;
jt900h_pkg::insn_t      ir, fetched;
logic                   is_djnz, taken;

assign fetched = mem_dout;
assign is_djnz = ir.opcode == jt900h_pkg::DJNZ;

always_comb begin
    case (ir.opcode)
        jt900h_pkg::JRZ:  taken = al.flags.z;
        jt900h_pkg::JRNZ: taken = !al.flags.z;
        jt900h_pkg::DJNZ: taken = !al.cnt_zero;   // counter not about to reach zero
        default:          taken = 1'b0;
    endcase
end

// register and ALU port
assign rg.src  = ir.src;
assign rg.dst  = ir.dst;
assign rg.we   = state == jt900h_pkg::S_WB;
assign rg.wsel = ir.opcode == jt900h_pkg::ALU || is_djnz;

assign al.op      = is_djnz ? jt900h_pkg::DEC : ir.op;
assign al.imm_sel = is_djnz;
assign al.go      = state == jt900h_pkg::S_GO ||
                    (state == jt900h_pkg::S_JUMP && is_djnz);

// memory and pc requests
assign mem_rd  = state == jt900h_pkg::S_FETCH || state == jt900h_pkg::S_IMM ||
                 state == jt900h_pkg::S_LDM;
assign mem_wr  = state == jt900h_pkg::S_STM;
assign mem_sel = state == jt900h_pkg::S_LDM || state == jt900h_pkg::S_STM;
assign pc_inc  = state == jt900h_pkg::S_FETCH || state == jt900h_pkg::S_IMM;
assign pc_rel  = state == jt900h_pkg::S_JUMP && taken;
assign rel_off = ir[7:0];
assign halted  = state == jt900h_pkg::S_HALT;

always_ff @(posedge clk) begin
    if (cen && state == jt900h_pkg::S_FWAIT && mem_rdy) ir <= fetched;
end

always_ff @(posedge clk) begin
    if (!rst_n) begin
        state <= jt900h_pkg::S_FETCH;
    end else if (cen) begin
        case (state)
            jt900h_pkg::S_FETCH: state <= jt900h_pkg::S_FWAIT;
            jt900h_pkg::S_FWAIT: begin
                if (mem_rdy) begin
                    case (fetched.opcode)     // decode straight off the bus word
                        jt900h_pkg::LDI:  state <= jt900h_pkg::S_IMM;
                        jt900h_pkg::ALU:  state <= jt900h_pkg::S_GO;
                        jt900h_pkg::LDM:  state <= jt900h_pkg::S_LDM;
                        jt900h_pkg::STM:  state <= jt900h_pkg::S_STM;
                        jt900h_pkg::JRZ,
                        jt900h_pkg::JRNZ,
                        jt900h_pkg::DJNZ: state <= jt900h_pkg::S_JUMP;
                        jt900h_pkg::HALT: state <= jt900h_pkg::S_HALT;
                        default:          state <= jt900h_pkg::S_FETCH;  // nop
                    endcase
                end
            end
            jt900h_pkg::S_IMM: state <= jt900h_pkg::S_IWAIT;
            jt900h_pkg::S_IWAIT: if (mem_rdy) state <= jt900h_pkg::S_WB;
            jt900h_pkg::S_GO: begin
                // cp only updates the flags
                state <= ir.op == jt900h_pkg::CP ? jt900h_pkg::S_FETCH : jt900h_pkg::S_WB;
            end
            jt900h_pkg::S_LDM: state <= jt900h_pkg::S_LWAIT;
            jt900h_pkg::S_LWAIT: if (mem_rdy) state <= jt900h_pkg::S_WB;
            jt900h_pkg::S_STM: state <= jt900h_pkg::S_SWAIT;
            jt900h_pkg::S_SWAIT: if (mem_rdy) state <= jt900h_pkg::S_FETCH;
            jt900h_pkg::S_JUMP: state <= is_djnz ? jt900h_pkg::S_WB : jt900h_pkg::S_FETCH;
            jt900h_pkg::S_HALT: state <= jt900h_pkg::S_HALT;  // until reset
            default: state <= jt900h_pkg::S_FETCH;
        endcase
    end
end

endmodule

//--- hw/jt900h_pc.sv
// ==========================================================
// jt900h_pc: program counter
// one step per fetch, signed relative branch
// ==========================================================
`timescale 1ns/1ps
`include "jt900h_macros.svh"

module jt900h_pc(
    input                         clk,
    input                         rst_n,
    input                         cen,
    input                         inc,
    input                         rel,
    input      [7:0]              off,   // signed, in words
    output logic [`JT900H_AW-1:0] pc
);

logic [`JT900H_AW-1:0] off_ext;

assign off_ext = {{(`JT900H_AW-8){off[7]}}, off};

always_ff @(posedge clk) begin
    if (!rst_n) begin
        pc <= '0;
    end else if (cen) begin
        if (inc)
            pc <= pc + 1'b1;
        else if (rel)
            pc <= pc + off_ext;     // pc already past the branch word
    end
end

endmodule

//--- hw/jt900h_ramctl.sv
// ==========================================================
// jt900h_ramctl: four-phase req/ack bus master
// fetch, load and store, one access at a time
// ==========================================================
`timescale 1ns/1ps
`include "jt900h_macros.svh"

module jt900h_ramctl(
    input                         clk,
    input                         rst_n,
    input                         cen,
    input                         mem_rd,
    input                         mem_wr,
    input                         mem_sel,
    input      [`JT900H_AW-1:0]   pc,
    input      [`JT900H_AW-1:0]   daddr,
    input      [`JT900H_DW-1:0]   wdata,
    output logic                  mem_rdy,
    output logic [`JT900H_DW-1:0] mem_dout,
    // external bus
    output logic [`JT900H_AW-1:0] ram_addr,
    output logic [`JT900H_DW-1:0] ram_wdata,
    output logic                  ram_we,
    output logic                  ram_req,
    input                         ram_ack,
    input      [`JT900H_DW-1:0]   ram_rdata
);

typedef enum logic [1:0] { IDLE, ACK_HI, ACK_LO } bus_state_t;

bus_state_t st;

always_ff @(posedge clk) begin
    if (!rst_n) begin
        st      <= IDLE;
        ram_req <= 1'b0;
        ram_we  <= 1'b0;
        mem_rdy <= 1'b0;
    end else if (cen) begin
        mem_rdy <= 1'b0;
        case (st)
            IDLE: if (mem_rd || mem_wr) begin
                ram_req <= 1'b1;
                ram_we  <= mem_wr;
                st      <= ACK_HI;
            end
            ACK_HI: if (ram_ack) begin
                ram_req <= 1'b0;
                st      <= ACK_LO;
            end
            ACK_LO: if (!ram_ack) begin   // bus free again
                ram_we  <= 1'b0;
                mem_rdy <= 1'b1;
                st      <= IDLE;
            end
            default: st <= IDLE;
        endcase
    end
end

// address, data and read word
always_ff @(posedge clk) begin
    if (cen) begin
        if (st == IDLE && (mem_rd || mem_wr)) begin
            ram_addr  <= mem_sel ? daddr : pc;
            ram_wdata <= wdata;
        end
        if (st == ACK_HI && ram_ack && !ram_we) mem_dout <= ram_rdata;
    end
end

endmodule

//--- hw/jt900h_alu.sv
// ==========================================================
// jt900h_alu: add, sub, logic ops, cp and dec
// registered result and z/c/s/v flags, djnz counter test
// ==========================================================
`timescale 1ns/1ps
`include "jt900h_macros.svh"

module jt900h_alu(
    input             clk,
    input             rst_n,
    input             cen,
    alu_if.alu        al,
    regs_if.alu       rg
);

localparam MSB = `JT900H_DW - 1;

logic [`JT900H_DW-1:0] a, b, r;
logic                  c, v;
jt900h_pkg::flags_t    nf;

assign a = rg.dst_out;
assign b = al.imm_sel ? {{MSB{1'b0}}, 1'b1} : rg.src_out;
assign al.cnt_zero = rg.dst_out == {{MSB{1'b0}}, 1'b1};  // last pass of djnz

always_comb begin
    r = a;
    c = 1'b0;
    v = 1'b0;
    case (al.op)
        jt900h_pkg::ADD: begin
            {c, r} = {1'b0, a} + {1'b0, b};
            v = (a[MSB] == b[MSB]) && (r[MSB] != a[MSB]);
        end
        jt900h_pkg::SUB, jt900h_pkg::CP, jt900h_pkg::DEC: begin
            {c, r} = {1'b0, a} - {1'b0, b};     // c is the borrow
            v = (a[MSB] != b[MSB]) && (r[MSB] != a[MSB]);
            if (al.op == jt900h_pkg::DEC) c = al.flags.c;
        end
        jt900h_pkg::AND: r = a & b;
        jt900h_pkg::OR:  r = a | b;
        jt900h_pkg::XOR: r = a ^ b;
        default:         r = a;
    endcase
    nf.z = r == '0;
    nf.c = c;
    nf.s = r[MSB];
    nf.v = v;
end

always_ff @(posedge clk) begin
    if (!rst_n) begin
        al.flags <= '0;
    end else if (cen && al.go) begin
        al.flags <= nf;
    end
end

always_ff @(posedge clk) begin
    if (cen && al.go) al.dout <= r;   // valid from the next cycle
end

endmodule

//--- hw/jt900h_regs.sv
// ==========================================================
// jt900h_regs: eight-entry register bank
// two read ports, one write port, byte-wide dump port
// ==========================================================
`timescale 1ns/1ps
`include "jt900h_macros.svh"

module jt900h_regs(
    input                         clk,
    input                         rst_n,
    input                         cen,
    regs_if.regs                  rg,
    input      [`JT900H_DW-1:0]   alu_dout,
    input      [`JT900H_DW-1:0]   mem_dout,
    input      [7:0]              dmp_addr,
    output logic [7:0]            dmp_din
);

logic [`JT900H_DW-1:0] bank [`JT900H_NREG];
logic [`JT900H_DW-1:0] dmp_word;

assign rg.src_out = bank[rg.src];
assign rg.dst_out = bank[rg.dst];
assign dmp_word   = bank[dmp_addr[3:1]];

always_ff @(posedge clk) begin
    if (!rst_n) begin
        for (int i = 0; i < `JT900H_NREG; i++) bank[i] <= '0;
    end else if (cen && rg.we) begin
        bank[rg.dst] <= rg.wsel ? alu_dout : mem_dout;
    end
end

// bit 0 picks the byte
always_ff @(posedge clk) begin
    if (cen) dmp_din <= dmp_addr[0] ? dmp_word[15:8] : dmp_word[7:0];
end

endmodule

//--- hw/jt900h_if.sv
// ==========================================================
// regs_if: register bank read/write port
// alu_if: ALU control, result and flags
// ==========================================================
`timescale 1ns/1ps
`include "jt900h_macros.svh"

interface regs_if;
    logic [`JT900H_RW-1:0] src, dst;
    logic                  we;
    logic                  wsel;      // 1 = ALU result, 0 = memory word
    logic [`JT900H_DW-1:0] src_out, dst_out;

    modport ctrl (output src, dst, we, wsel);
    modport regs (input src, dst, we, wsel, output src_out, dst_out);
    modport alu  (input src_out, dst_out);
endinterface

interface alu_if;
    jt900h_pkg::alu_op_t   op;
    logic                  go;
    logic                  imm_sel;   // constant one replaces src
    logic [`JT900H_DW-1:0] dout;
    jt900h_pkg::flags_t    flags;
    logic                  cnt_zero;

    modport ctrl (output op, go, imm_sel, input flags, cnt_zero);
    modport alu  (input op, go, imm_sel, output dout, flags, cnt_zero);
endinterface

//--- hw/jt900h_pkg.sv
// ==========================================================
// jt900h_pkg: shared types for the cut-down 900H core
// opcode, ALU operation, flags, instruction word layout
// and the controller state encoding
// ==========================================================
package jt900h_pkg;

    // top nibble of each instruction word
    typedef enum logic [3:0] {
        LDI  = 4'd0,    // second word is the immediate
        ALU  = 4'd1,
        LDM  = 4'd2,    // dst <= mem[src]
        STM  = 4'd3,    // mem[src] <= dst
        JRZ  = 4'd4,
        JRNZ = 4'd5,
        DJNZ = 4'd6,
        HALT = 4'd7
    } opcode_t;

    typedef enum logic [2:0] {
        ADD, SUB, AND, OR, XOR, CP, DEC
    } alu_op_t;

    typedef struct packed {
        logic z;
        logic c;
        logic s;
        logic v;
    } flags_t;

    // jumps read the low byte as a signed word offset
    typedef struct packed {
        opcode_t     opcode;
        logic [2:0]  dst;
        logic [2:0]  src;
        alu_op_t     op;
        logic [2:0]  spare;
    } insn_t;

    typedef enum logic [3:0] {
        S_FETCH, S_FWAIT, S_IMM, S_IWAIT, S_GO, S_WB,
        S_LDM, S_LWAIT, S_STM, S_SWAIT, S_JUMP, S_HALT
    } cpu_state_t;

endpackage

//--- include/jt900h_macros.svh
// ==========================================================
// width and size macros for the cut-down 900H core
// data, address and register index widths, register count
// ==========================================================
`ifndef JT900H_MACROS_SVH
`define JT900H_MACROS_SVH

`define JT900H_DW   16  // data and instruction word
`define JT900H_AW   16  // external address, in words
`define JT900H_NREG 8   // register bank entries
`define JT900H_RW   3   // register index

`endif
